// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
TOP       = tb_sms_host
FILELIST  = sms_host.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/sms_host_golden.txt
# command  arg_a  arg_b, all values in hex
# ce cycles | dl size header | probe addr expected | mount readonly nonempty
# fill seed | nvrd addr expected | nvwr addr data | save | savechk addr expected
ce 3c 0
dl 2000 0
probe 000000 000000
probe 001234 001234
probe 002345 000345
probe 3fffff 001fff
probe 012abc 000abc
dl 4200 1
probe 000000 000200
probe 001234 001434
probe 003f00 000100
probe 005e00 002000
fill 5a 0
mount 0 1
dl 1000 0
probe 001234 000234
nvrd 0000 5a
nvrd 1234 7c
nvrd 7fff da
nvwr 0123 a5
nvrd 0123 a5
save 0 0
savechk 0123 a5
savechk 7fff da
savechk 0200 58

// File: bench/sms_host_sva.sv
//==================================================
// Handshake assertions for the ROM write toggle
// and the sector request and acknowledge
//==================================================
module rom_handshake_sva (
	input logic clk_sys,
	input logic reset,
	input logic dl_active,
	input logic dl_wr,
	input logic ioctl_wait,
	input logic rom_wr
);
	timeunit 1ns;
	timeprecision 1ps;

	// New ROM request only for a host write taken while not waiting
	a_rom_toggle: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_wr != $past(rom_wr)) |-> $past(dl_active && dl_wr && !ioctl_wait))
	else $error("rom_wr toggled without a host write while ioctl_wait was low");

endmodule

module sector_handshake_sva (
	input logic clk_sys,
	input logic reset,
	input logic sd_ack,
	input logic sd_rd,
	input logic sd_wr
);
	timeunit 1ns;
	timeprecision 1ps;

	a_one_request: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr))
	else $error("sd_rd and sd_wr high together");

	// Request drops one edge after ack rises
	a_rd_drop: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(sd_rd) |-> ($past(sd_ack) && !$past(sd_ack, 2)))
	else $error("sd_rd fell without a rising ack");

	a_wr_drop: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(sd_wr) |-> ($past(sd_ack) && !$past(sd_ack, 2)))
	else $error("sd_wr fell without a rising ack");

endmodule

bind cart_loader rom_handshake_sva u_rom_sva (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.dl_active  (dl.active),
	.dl_wr      (dl.wr),
	.ioctl_wait (ioctl_wait),
	.rom_wr     (rom_wr)
);

bind backup_ctrl sector_handshake_sva u_sector_sva (
	.clk_sys (clk_sys),
	.reset   (reset),
	.sd_ack  (sd.ack),
	.sd_rd   (sd_rd),
	.sd_wr   (sd_wr)
);

// File: bench/tb_sms_host.sv
//==================================================
// Testbench for the console host wrapper
// Golden-file command loop, ROM and sector host
// models, value compare and failure handling
//==================================================
module tb_sms_host
	import sms_host_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int    NVRAM_AW    = 15;
	localparam int    NVRAM_BYTES = 2 ** NVRAM_AW;
	localparam int    SECTORS     = NVRAM_BYTES / SECTOR_BYTES;
	localparam int    WAIT_LIMIT  = 64;
	localparam int    XFER_LIMIT  = 200000;
	localparam string GOLDEN_FILE = "bench/sms_host_golden.txt";

	logic                clk_sys;
	logic                reset;
	dl_port_t            dl;
	sd_host_t            sd;
	logic                img_mounted;
	logic                img_readonly;
	logic                img_nonempty;
	logic                bk_load_req;
	logic                bk_save_req;
	logic                ioctl_wait;
	rom_addr_t           rom_waddr;
	byte_t               rom_wdata;
	logic                rom_wr;
	logic                rom_we_ack;
	rom_addr_t           rom_addr_in;
	rom_addr_t           rom_raddr;
	logic                sd_rd;
	logic                sd_wr;
	logic [5:0]          sd_lba;
	byte_t               sd_buff_din;
	logic                ce_cpu;
	logic                ce_vdp;
	logic                ce_pix;
	logic                ce_sp;
	logic                core_reset;
	logic [NVRAM_AW-1:0] nvram_addr;
	logic                nvram_we;
	byte_t               nvram_d;
	byte_t               nvram_q;

	byte_t rom_mem [65536];
	byte_t image [NVRAM_BYTES];
	byte_t exp_ram [NVRAM_BYTES];
	byte_t saved [NVRAM_BYTES];
	int    cyc;
	int    sectors_done;
	int    fail_count;

	sms_host #(.NVRAM_AW(NVRAM_AW)) u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Edges since reset release
	always @(posedge clk_sys) begin
		if (reset) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	// ==================================================
	// Helpers
	// ==================================================

	task automatic abort_run(input string reason);
		fail_count++;
		$display("ERROR: %s", reason);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
			abort_run("value check failed");
		end
	endtask

	function automatic byte_t dl_byte(input int unsigned i);
		return byte_t'(i ^ (i >> 8) ^ (i >> 16));
	endfunction

	function automatic byte_t fill_byte(input int unsigned i, input byte_t seed);
		return byte_t'(i ^ (i >> 8)) ^ seed;
	endfunction

	// ==================================================
	// ROM and sector host models
	// ==================================================

	initial begin : rom_model
		int unsigned lag;
		rom_we_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!reset && (rom_wr != rom_we_ack)) begin
				lag = $urandom % 5;
				repeat (lag) @(negedge clk_sys);
				rom_mem[rom_waddr[15:0]] = rom_wdata;
				rom_we_ack = rom_wr;
			end
		end
	end

	initial begin : sector_host
		int   base;
		int   gap;
		logic is_load;
		sd = '0;
		sectors_done = 0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				is_load = sd_rd;
				base = int'(sd_lba) * SECTOR_BYTES;
				gap = 1 + int'($urandom % 4);
				repeat (gap) @(negedge clk_sys);
				sd.ack = 1'b1;
				for (int k = 0; k < SECTOR_BYTES; k++) begin
					sd.buff_addr = buf_addr_t'(k);
					if (is_load) begin
						sd.buff_wr   = 1'b1;
						sd.buff_data = image[base + k];
					end
					@(negedge clk_sys);
					// RAM output trails the buffer address by one edge
					if (!is_load) begin
						saved[base + k] = sd_buff_din;
					end
				end
				sd.buff_wr = 1'b0;
				sd.ack     = 1'b0;
				sectors_done++;
			end
		end
	end

	// ==================================================
	// Command tasks
	// ==================================================

	task automatic check_enables(input int cycles);
		int c;
		int n_cpu;
		int n_vdp;
		int n_pix;
		int n_sp;
		n_cpu = 0;
		n_vdp = 0;
		n_pix = 0;
		n_sp = 0;
		for (int k = 0; k < cycles; k++) begin
			@(negedge clk_sys);
			// Enables show the count of the edge before
			c = (cyc - 1) % 30;
			compare_value("ce_sp", 32'(ce_sp), 32'(c % 2 == 1));
			compare_value("ce_vdp", 32'(ce_vdp), 32'(c % 5 == 4));
			compare_value("ce_pix", 32'(ce_pix), 32'(c % 10 == 9));
			compare_value("ce_cpu", 32'(ce_cpu), 32'(c == 9 || c == 24));
			n_cpu += int'(ce_cpu);
			n_vdp += int'(ce_vdp);
			n_pix += int'(ce_pix);
			n_sp += int'(ce_sp);
		end
		compare_value("ce_cpu count", n_cpu, 2 * cycles / 30);
		compare_value("ce_vdp count", n_vdp, 6 * cycles / 30);
		compare_value("ce_pix count", n_pix, 3 * cycles / 30);
		compare_value("ce_sp count", n_sp, 15 * cycles / 30);
	endtask

	task automatic download(input int size, input logic hdr);
		int   waited;
		logic load_due;
		load_due = img_mounted && !img_readonly && img_nonempty;
		sectors_done = 0;
		// Previous image is wiped
		for (int i = 0; i < $size(rom_mem); i++) begin
			rom_mem[i] = 'x;
		end
		@(negedge clk_sys);
		dl.active = 1'b1;
		for (int i = 0; i < size; i++) begin
			@(negedge clk_sys);
			dl.wr   = 1'b1;
			dl.addr = dl_addr_t'(i);
			dl.data = dl_byte(i);
			@(negedge clk_sys);
			dl.wr = 1'b0;
			waited = 0;
			while (ioctl_wait) begin
				@(negedge clk_sys);
				waited++;
				if (waited > WAIT_LIMIT) begin
					abort_run("ioctl_wait stuck high during a download");
				end
			end
		end
		@(negedge clk_sys);
		dl.active = 1'b0;
		// Core reset covers an automatic backup load
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
			if (waited > XFER_LIMIT) begin
				abort_run("core_reset did not fall after the download");
			end
		end while (core_reset);
		compare_value("ioctl_wait", 32'(ioctl_wait), 0);
		compare_value("has_header", 32'(u_dut.u_cart.has_header), 32'(hdr));
		compare_value("loaded sectors", sectors_done, load_due ? SECTORS : 0);
		if (load_due) begin
			exp_ram = image;
		end
		for (int i = 0; i < size; i++) begin
			compare_value($sformatf("rom_mem[%0h]", i), 32'(rom_mem[i[15:0]]), 32'(dl_byte(i)));
		end
	endtask

	task automatic probe_read(input rom_addr_t addr, input rom_addr_t exp);
		@(negedge clk_sys);
		rom_addr_in = addr;
		@(negedge clk_sys);
		compare_value("rom_raddr", 32'(rom_raddr), 32'(exp));
	endtask

	task automatic core_read(input logic [NVRAM_AW-1:0] addr, input byte_t exp);
		@(negedge clk_sys);
		nvram_addr = addr;
		@(negedge clk_sys);
		compare_value("nvram_q", 32'(nvram_q), 32'(exp));
	endtask

	task automatic core_write(input logic [NVRAM_AW-1:0] addr, input byte_t data);
		@(negedge clk_sys);
		nvram_addr = addr;
		nvram_d    = data;
		nvram_we   = 1'b1;
		@(negedge clk_sys);
		nvram_we = 1'b0;
		exp_ram[addr] = data;
		compare_value("bk_pending", 32'(u_dut.bk_pending), 1);
	endtask

	task automatic save_backup();
		int waited;
		sectors_done = 0;
		@(negedge clk_sys);
		bk_save_req = 1'b1;
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
			if (waited > WAIT_LIMIT) begin
				abort_run("backup save did not start");
			end
		end while (u_dut.u_bk.state == BK_IDLE);
		bk_save_req = 1'b0;
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
			if (waited > XFER_LIMIT) begin
				abort_run("backup save did not finish");
			end
		end while (u_dut.u_bk.state != BK_IDLE);
		compare_value("saved sectors", sectors_done, SECTORS);
		compare_value("bk_pending", 32'(u_dut.bk_pending), 0);
		for (int i = 0; i < NVRAM_BYTES; i++) begin
			compare_value($sformatf("saved[%0h]", i), 32'(saved[i]), 32'(exp_ram[i]));
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin : main
		int          fd;
		int          n;
		string       line;
		string       cmd;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		void'($urandom(32'h8a39_0a45));
		fail_count   = 0;
		reset        = 1'b1;
		dl           = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_nonempty = 1'b0;
		bk_load_req  = 1'b0;
		bk_save_req  = 1'b0;
		rom_addr_in  = '0;
		nvram_addr   = '0;
		nvram_we     = 1'b0;
		nvram_d      = '0;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;

		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			abort_run("cannot open the golden file");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			arg_a = '0;
			arg_b = '0;
			n = $sscanf(line, "%s %h %h", cmd, arg_a, arg_b);
			if (n < 1) begin
				continue;
			end
			if (cmd == "ce") begin
				check_enables(int'(arg_a));
			end else if (cmd == "dl") begin
				download(int'(arg_a), arg_b[0]);
			end else if (cmd == "probe") begin
				probe_read(rom_addr_t'(arg_a), rom_addr_t'(arg_b));
			end else if (cmd == "mount") begin
				@(negedge clk_sys);
				img_mounted  = 1'b1;
				img_readonly = arg_a[0];
				img_nonempty = arg_b[0];
			end else if (cmd == "fill") begin
				for (int i = 0; i < NVRAM_BYTES; i++) begin
					image[i] = fill_byte(i, byte_t'(arg_a));
				end
			end else if (cmd == "nvrd") begin
				core_read(arg_a[NVRAM_AW-1:0], byte_t'(arg_b));
			end else if (cmd == "nvwr") begin
				core_write(arg_a[NVRAM_AW-1:0], byte_t'(arg_b));
			end else if (cmd == "save") begin
				save_backup();
			end else if (cmd == "savechk") begin
				compare_value($sformatf("saved[%0h]", arg_a),
					32'(saved[arg_a[NVRAM_AW-1:0]]), arg_b);
			end else begin
				abort_run({"unknown command in the golden file: ", cmd});
			end
		end
		$fclose(fd);

		if (fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: hdl/backup_ctrl.sv
//==================================================
// Backup RAM controller
// Backup enable and dirty flag, sector load and
// save sequencing, core reset generation
//==================================================
module backup_ctrl
	import sms_host_pkg::*;
#(
	parameter int NVRAM_AW = 15
)
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_active,
	input  logic       img_mounted,
	input  logic       img_readonly,
	input  logic       img_nonempty,
	input  logic       bk_load_req,
	input  logic       bk_save_req,
	input  logic       core_we,
	input  sd_host_t   sd,
	output logic       sd_rd,
	output logic       sd_wr,
	output logic [5:0] sd_lba,
	output logic       core_reset,
	output logic       bk_ena,
	output logic       bk_pending
);

	// Sectors per backup image
	localparam int         SECTORS  = 2 ** (NVRAM_AW - $clog2(SECTOR_BYTES));
	localparam logic [5:0] LAST_LBA = 6'(SECTORS - 1);

	bk_state_e state;
	logic      dl_active_q;
	logic      load_q;
	logic      save_q;
	logic      ack_q;
	logic      dl_start;
	logic      dl_end;
	logic      load_rise;
	logic      save_rise;

	assign dl_start  = dl_active & ~dl_active_q;
	assign dl_end    = ~dl_active & dl_active_q;
	assign load_rise = bk_ena & bk_load_req & ~load_q;
	assign save_rise = bk_ena & bk_save_req & ~save_q;

	// dl_active_q bridges the cycle before the automatic load starts
	assign core_reset = reset | dl_active | dl_active_q | (state == BK_LOAD);

	// ==================================================
	// Backup enable and dirty flag
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			if (dl_start) begin
				bk_ena <= 1'b0;
			end
			// Save image is mounted while the cartridge streams in
			if (dl_active && img_mounted && !img_readonly) begin
				bk_ena <= 1'b1;
			end
			if (bk_ena && core_we) begin
				bk_pending <= 1'b1;
			end else if (state != BK_IDLE) begin
				bk_pending <= 1'b0;
			end
		end
	end

	// ==================================================
	// Sector transfer
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= BK_IDLE;
			dl_active_q <= 1'b0;
			load_q      <= 1'b0;
			save_q      <= 1'b0;
			ack_q       <= 1'b0;
			sd_rd       <= 1'b0;
			sd_wr       <= 1'b0;
			sd_lba      <= '0;
		end else begin
			dl_active_q <= dl_active;
			load_q      <= bk_load_req;
			save_q      <= bk_save_req;
			ack_q       <= sd.ack;

			// Host took the request
			if (sd.ack && !ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if ((dl_end && img_nonempty && bk_ena) || load_rise) begin
						state  <= BK_LOAD;
						sd_lba <= '0;
						sd_rd  <= 1'b1;
					end else if (save_rise) begin
						state  <= BK_SAVE;
						sd_lba <= '0;
						sd_wr  <= 1'b1;
					end
				end
				default: begin
					// Sector done on the falling edge of ack
					if (!sd.ack && ack_q) begin
						if (sd_lba == LAST_LBA) begin
							state <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 6'd1;
							sd_rd  <= (state == BK_LOAD);
							sd_wr  <= (state == BK_SAVE);
						end
					end
				end
			endcase
		end
	end

endmodule

// File: hdl/backup_ram.sv
//==================================================
// Backup RAM, true dual port, one byte wide
// Port A for the core, port B for sector buffers
//==================================================
module backup_ram
	import sms_host_pkg::*;
#(
	parameter int NVRAM_AW = 15
)
(
	input  logic                clk_sys,
	input  logic [NVRAM_AW-1:0] a_addr,
	input  logic                a_we,
	input  byte_t               a_d,
	output byte_t               a_q,
	input  logic [NVRAM_AW-1:0] b_addr,
	input  logic                b_we,
	input  byte_t               b_d,
	output byte_t               b_q
);

	byte_t mem [2**NVRAM_AW];

	// Read returns old data on a same-address write
	always_ff @(posedge clk_sys) begin
		if (a_we) begin
			mem[a_addr] <= a_d;
		end
		if (b_we) begin
			mem[b_addr] <= b_d;
		end
		a_q <= mem[a_addr];
		b_q <= mem[b_addr];
	end

endmodule

// File: hdl/cart_loader.sv
//==================================================
// Cartridge loader
// Toggle write handshake into external ROM,
// image mask and header learning,
// read address translation for the core
//==================================================
module cart_loader
	import sms_host_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  dl_port_t  dl,
	output logic      ioctl_wait,
	output rom_addr_t rom_waddr,
	output byte_t     rom_wdata,
	output logic      rom_wr,
	input  logic      rom_we_ack,
	input  rom_addr_t rom_addr_in,
	output rom_addr_t rom_raddr
);

	localparam rom_addr_t HDR_OFFSET = rom_addr_t'(SECTOR_BYTES);
	localparam dl_addr_t  HDR_START  = dl_addr_t'(SECTOR_BYTES);
	localparam int        HDR_BIT    = $clog2(SECTOR_BYTES);

	logic      active_q;
	logic      dl_start;
	logic      dl_end;
	logic      dl_write;
	rom_addr_t dl_rom_addr;
	rom_addr_t rom_mask;
	rom_addr_t hdr_mask;
	logic      has_header;

	assign dl_start    = dl.active & ~active_q;
	assign dl_end      = ~dl.active & active_q;
	assign dl_write    = dl.active & dl.wr;
	assign dl_rom_addr = dl.addr[$bits(rom_addr_t)-1:0];

	// ==================================================
	// ROM write handshake
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q   <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_wr     <= 1'b0;
			rom_waddr  <= '0;
		end else begin
			active_q <= dl.active;
			if (dl_write) begin
				// Each new byte flips the request and holds the host
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr;
			end else if (ioctl_wait && (rom_wr == rom_we_ack)) begin
				ioctl_wait <= 1'b0;
				rom_waddr  <= rom_waddr + 1'b1;
			end
			// New image always starts at 0
			if (dl_start) begin
				rom_waddr <= '0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dl_write) begin
			rom_wdata <= dl.data;
		end
	end

	// ==================================================
	// Image size and header detection
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_mask   <= '1;
			hdr_mask   <= '1;
			has_header <= 1'b0;
		end else begin
			if (dl_write) begin
				rom_mask <= rom_mask | dl_rom_addr;
				hdr_mask <= hdr_mask | (dl_rom_addr - HDR_OFFSET);
				// Restart both masks at their first byte
				if (dl.addr == '0) begin
					rom_mask <= '0;
				end
				if (dl.addr == HDR_START) begin
					hdr_mask <= '0;
				end
			end
			// Byte count is an odd multiple of 512 with a header
			if (dl_end) begin
				has_header <= rom_waddr[HDR_BIT];
			end
		end
	end

	// Core reads skip the header and wrap at the image size
	always_comb begin
		if (has_header) begin
			rom_raddr = (rom_addr_in + HDR_OFFSET) & hdr_mask;
		end else begin
			rom_raddr = rom_addr_in & rom_mask;
		end
	end

endmodule

// File: hdl/ce_sequencer.sv
//==================================================
// Clock-enable sequencer for the console core
// 30-phase counter with registered CPU, VDP,
// pixel and sprite enables
//==================================================
module ce_sequencer (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	localparam logic [4:0] LAST_PHASE = 5'd29;

	logic [4:0] phase;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase  <= 5'd0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			phase <= (phase == LAST_PHASE) ? 5'd0 : phase + 5'd1;
			// Sprite engine runs at half rate
			ce_sp  <= phase[0];
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			// VDP every 5, pixel every 10, CPU every 15 with shifted phase
			case (phase)
				5'd4, 5'd14: ce_vdp <= 1'b1;
				5'd9: begin
					ce_cpu <= 1'b1;
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				5'd19, 5'd29: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				5'd24: begin
					ce_cpu <= 1'b1;
					ce_vdp <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: hdl/sms_host.sv
//==================================================
// Console host wrapper top level
// Clock enables, cartridge loader, backup
// controller and backup RAM
//==================================================
module sms_host
	import sms_host_pkg::*;
#(
	parameter int NVRAM_AW = 15
)
(
	input  logic                clk_sys,
	input  logic                reset,

	// Host download, sector host and mount status
	input  dl_port_t            dl,
	input  sd_host_t            sd,
	input  logic                img_mounted,
	input  logic                img_readonly,
	input  logic                img_nonempty,
	input  logic                bk_load_req,
	input  logic                bk_save_req,
	output logic                ioctl_wait,

	// External ROM write and read translation
	output rom_addr_t           rom_waddr,
	output byte_t               rom_wdata,
	output logic                rom_wr,
	input  logic                rom_we_ack,
	input  rom_addr_t           rom_addr_in,
	output rom_addr_t           rom_raddr,

	// Sector requests
	output logic                sd_rd,
	output logic                sd_wr,
	output logic [5:0]          sd_lba,
	output byte_t               sd_buff_din,

	// Core side
	output logic                ce_cpu,
	output logic                ce_vdp,
	output logic                ce_pix,
	output logic                ce_sp,
	output logic                core_reset,
	input  logic [NVRAM_AW-1:0] nvram_addr,
	input  logic                nvram_we,
	input  byte_t               nvram_d,
	output byte_t               nvram_q
);

	// Dirty flag for an OSD menu or disk LED
	logic                bk_pending;
	logic [NVRAM_AW-1:0] sector_addr;

	// Sector number selects the 512-byte page
	assign sector_addr = {sd_lba[NVRAM_AW-$clog2(SECTOR_BYTES)-1:0], sd.buff_addr};

	ce_sequencer u_ce (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	cart_loader u_cart (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.ioctl_wait  (ioctl_wait),
		.rom_waddr   (rom_waddr),
		.rom_wdata   (rom_wdata),
		.rom_wr      (rom_wr),
		.rom_we_ack  (rom_we_ack),
		.rom_addr_in (rom_addr_in),
		.rom_raddr   (rom_raddr)
	);

	backup_ctrl #(.NVRAM_AW(NVRAM_AW)) u_bk (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl.active),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_nonempty (img_nonempty),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.core_we      (nvram_we),
		.sd           (sd),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_lba       (sd_lba),
		.core_reset   (core_reset),
		.bk_ena       (),
		.bk_pending   (bk_pending)
	);

	backup_ram #(.NVRAM_AW(NVRAM_AW)) u_nvram (
		.clk_sys (clk_sys),
		.a_addr  (nvram_addr),
		.a_we    (nvram_we),
		.a_d     (nvram_d),
		.a_q     (nvram_q),
		.b_addr  (sector_addr),
		.b_we    (sd.buff_wr),
		.b_d     (sd.buff_data),
		.b_q     (sd_buff_din)
	);

endmodule

// File: hdl/sms_host_pkg.sv
//==================================================
// Shared definitions for the console host wrapper
// Data and address widths, host download port,
// sector host return bundle, backup state encoding
//==================================================
package sms_host_pkg;

	// ==================================================
	// Widths with a meaning
	// ==================================================

	// One data byte on any of the buses
	typedef logic [7:0]  byte_t;

	// Cartridge ROM address, 4 MB space
	typedef logic [21:0] rom_addr_t;

	// Host download address as sent by the host
	typedef logic [24:0] dl_addr_t;

	// Offset inside one sector buffer
	typedef logic [8:0]  buf_addr_t;

	// Sector size, also the size of an optional image header
	localparam int SECTOR_BYTES = 512;

	// ==================================================
	// Bundles
	// ==================================================

	// Host download port
	typedef struct packed {
		logic     active;
		logic     wr;
		dl_addr_t addr;
		byte_t    data;
	} dl_port_t;

	// What the sector host hands back during a transfer
	typedef struct packed {
		logic      ack;
		logic      buff_wr;
		buf_addr_t buff_addr;
		byte_t     buff_data;
	} sd_host_t;

	// Backup transfer state
	typedef enum logic [1:0] {
		BK_IDLE = 2'd0,
		BK_LOAD = 2'd1,
		BK_SAVE = 2'd2
	} bk_state_e;

endpackage

// File: sms_host.f
hdl/sms_host_pkg.sv
hdl/ce_sequencer.sv
hdl/cart_loader.sv
hdl/backup_ctrl.sv
hdl/backup_ram.sv
hdl/sms_host.sv
bench/sms_host_sva.sv
bench/tb_sms_host.sv
